// ==== logic/i2f_params.svh ====
/*
  width, IEEE single field and register offset macros for the
  integer to float converter
*/
`ifndef I2F_PARAMS_SVH
`define I2F_PARAMS_SVH

// integer operand width, also the width of the APB data bus
`define I2F_WIDTH 32

// IEEE-754 single precision fields
`define I2F_MANT_BITS 23
`define I2F_EXP_BIAS 127

// APB register offsets, all word aligned
`define I2F_ADDR_CTRL 8'h00
`define I2F_ADDR_OPERAND 8'h04
`define I2F_ADDR_RESULT 8'h08
`define I2F_ADDR_FLAGS 8'h0C

`endif

// ==== logic/i2f_pkg.sv ====
/*
  i2f_pkg: vector types, request and result structs and the APB
  transfer phase enum shared by the converter blocks
*/
`include "i2f_params.svh"

package i2f_pkg;

  // integer operand, or its magnitude once the sign is stripped
  typedef logic [`I2F_WIDTH-1:0] int_word_t;

  // zero count coming out of the leading and trailing counters
  typedef logic [$clog2(`I2F_WIDTH)-1:0] zcount_t;

  // packed single precision float, sign in bit 31
  typedef logic [31:0] fp32_t;

  // byte address seen on the APB bus
  typedef logic [7:0] apb_addr_t;

  // what the register block asks the core to convert
  typedef struct packed {
    int_word_t operand;
    logic      is_signed;
  } i2f_req_t;

  // converted value plus the two status flags
  typedef struct packed {
    fp32_t value;
    logic  inexact;
    logic  zero;
  } i2f_res_t;

  // APB transfer phase as seen by the slave
  typedef enum logic [1:0] {
    idle,
    setup,
    access
  } apb_phase_e;

endpackage

// ==== logic/fpuv_lzc.sv ====
/*
  fpuv_lzc: leading or trailing zero counter built as a binary tree
  search for the first set bit, with an all-zero flag
*/
module fpuv_lzc #(
  // number of input bits, at least 2
  parameter int unsigned WIDTH = 2,
  // 1 counts leading zeros from the top, 0 counts trailing zeros from bit 0
  parameter bit          MODE  = 1'b0
) (
  input  logic [WIDTH-1:0]         in,
  output logic [$clog2(WIDTH)-1:0] cnt,
  output logic                     empty
);

  localparam int unsigned LEVELS = $clog2(WIDTH);
  localparam int unsigned LEAVES = 2 ** LEVELS;
  localparam int unsigned NODES  = 2 * LEAVES - 1;

  // leaf vector, ordered so that the wanted bit is the lowest set one
  logic [LEAVES-1:0] bits;

  // tree kept as a heap, node n has children 2n+1 and 2n+2
  // node_any says a set bit exists below the node
  logic [NODES-1:0] node_any;
  // node_idx is the lowest set leaf index below the node
  logic [NODES-1:0][LEVELS-1:0] node_idx;

  for (genvar k = 0; k < int'(LEAVES); k++) begin : g_leaf
    if (k >= int'(WIDTH)) begin : g_pad
      // leaves past the input width never hold a set bit
      assign bits[k] = 1'b0;
    end else if (MODE) begin : g_flip
      // leading mode looks from the msb, so the vector is reversed
      assign bits[k] = in[WIDTH-1-k];
    end else begin : g_keep
      assign bits[k] = in[k];
    end

    // leaves sit at the back of the heap
    assign node_any[LEAVES-1+k] = bits[k];
    assign node_idx[LEAVES-1+k] = LEVELS'(k);
  end

  for (genvar n = 0; n < int'(LEAVES) - 1; n++) begin : g_node
    // a node is hit if either child is hit
    assign node_any[n] = node_any[2*n+1] | node_any[2*n+2];

    // the left child covers the lower indices and wins whenever it is hit
    assign node_idx[n] = node_any[2*n+1] ? node_idx[2*n+1] : node_idx[2*n+2];
  end

  // the root holds the index of the first set bit, which is the zero count
  // with an all-zero input the count falls on the last leaf
  assign cnt   = node_idx[0];
  assign empty = ~node_any[0];

endmodule

// ==== logic/i2f_norm_round.sv ====
/*
  i2f_norm_round: normalization shift, guard and sticky extraction,
  round to nearest even and packing of the single precision result
*/
`include "i2f_params.svh"

module i2f_norm_round import i2f_pkg::*; (
  input  int_word_t mag,
  input  logic      sign,
  input  zcount_t   lz,
  input  zcount_t   tz,
  input  logic      empty,
  output i2f_res_t  res
);

  localparam int unsigned MANT_BITS = `I2F_MANT_BITS;
  localparam int unsigned EXP_BITS  = 31 - MANT_BITS;
  // position of the guard bit after the magnitude is normalized
  localparam int unsigned GUARD_POS = `I2F_WIDTH - 2 - MANT_BITS;
  // exponent of a value whose top bit sits at bit 31
  localparam int unsigned EXP_TOP   = `I2F_EXP_BIAS + `I2F_WIDTH - 1;

  int_word_t             shifted;
  logic [MANT_BITS-1:0]  mant;
  logic                  guard;
  logic                  sticky;
  logic [5:0]            zero_sum;
  logic                  round_up;
  logic [MANT_BITS:0]    mant_sum;
  logic [EXP_BITS-1:0]   exp_base;
  logic [EXP_BITS-1:0]   exp_final;

  // the leading one lands in bit 31 and is implied in the float
  assign shifted = mag << lz;
  assign mant    = shifted[`I2F_WIDTH-2 -: MANT_BITS];
  assign guard   = shifted[GUARD_POS];

  // a set bit lies below guard when tz < GUARD_POS - lz
  // written as a sum so it never goes negative for large lz
  assign zero_sum = {1'b0, tz} + {1'b0, lz};
  assign sticky   = zero_sum < 6'(GUARD_POS);

  // round to nearest, ties go to the even mantissa
  assign round_up = guard & (sticky | mant[0]);

  // the extra top bit catches a mantissa of all ones rolling over
  assign mant_sum = {1'b0, mant} + {{MANT_BITS{1'b0}}, round_up};

  // biased exponent before and after the rounding carry
  assign exp_base  = EXP_BITS'(EXP_TOP) - EXP_BITS'(lz);
  assign exp_final = exp_base + EXP_BITS'(mant_sum[MANT_BITS]);

  always_comb begin
    if (empty) begin
      // a zero operand maps to +0.0 and is always exact
      res.value   = '0;
      res.inexact = 1'b0;
      res.zero    = 1'b1;
    end else begin
      // on overflow mant_sum is all zeros below the carry, which is correct
      res.value   = {sign, exp_final, mant_sum[MANT_BITS-1:0]};
      res.inexact = guard | sticky;
      res.zero    = 1'b0;
    end
  end

endmodule

// ==== logic/i2f_core.sv ====
/*
  i2f_core: sign and magnitude of the operand, parallel leading and
  trailing zero counters, and the normalize and round stage
*/
`include "i2f_params.svh"

module i2f_core import i2f_pkg::*; (
  input  i2f_req_t req,
  output i2f_res_t res
);

  logic      sign;
  int_word_t mag;
  zcount_t   lz_cnt;
  zcount_t   tz_cnt;
  logic      lz_empty;
  logic      tz_empty;
  logic      mag_zero;

  // only a signed operand with its msb set is negative
  assign sign = req.is_signed & req.operand[`I2F_WIDTH-1];

  // two's complement of -2^31 wraps to 2^31, which is the right magnitude
  assign mag = sign ? int_word_t'(-req.operand) : req.operand;

  // leading zeros give the normalization shift
  fpuv_lzc #(
    .WIDTH (`I2F_WIDTH),
    .MODE  (1'b1)
  ) lead_lzc_i (
    .in    (mag),
    .cnt   (lz_cnt),
    .empty (lz_empty)
  );

  // trailing zeros tell the rounder whether any set bit falls below guard
  fpuv_lzc #(
    .WIDTH (`I2F_WIDTH),
    .MODE  (1'b0)
  ) trail_lzc_i (
    .in    (mag),
    .cnt   (tz_cnt),
    .empty (tz_empty)
  );

  // both counters see the same magnitude and agree on an all-zero input
  assign mag_zero = lz_empty & tz_empty;

  i2f_norm_round norm_round_i (
    .mag   (mag),
    .sign  (sign),
    .lz    (lz_cnt),
    .tz    (tz_cnt),
    .empty (mag_zero),
    .res   (res)
  );

endmodule

// ==== logic/i2f_apb_regs.sv ====
/*
  i2f_apb_regs: APB slave holding the control and operand registers,
  capturing the conversion result and flags one cycle after a write
*/
`include "i2f_params.svh"

module i2f_apb_regs import i2f_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  int_word_t pwdata,
  output int_word_t prdata,
  output logic      pready,
  output logic      pslverr,
  output i2f_req_t  req,
  input  i2f_res_t  res
);

  apb_phase_e phase;

  logic hit_ctrl;
  logic hit_operand;
  logic hit_result;
  logic hit_flags;
  logic mapped;
  logic read_only;
  logic wr_ctrl;
  logic wr_operand;

  // register contents
  logic      ctrl_signed;
  int_word_t operand;
  fp32_t     result;
  logic      flag_inexact;
  logic      flag_zero;
  logic      capture_pending;

  // the phase follows straight from psel and penable
  always_comb begin
    if (!psel) begin
      phase = idle;
    end else if (!penable) begin
      phase = setup;
    end else begin
      phase = access;
    end
  end

  // address decode, the master keeps paddr stable over the whole transfer
  assign hit_ctrl    = paddr == `I2F_ADDR_CTRL;
  assign hit_operand = paddr == `I2F_ADDR_OPERAND;
  assign hit_result  = paddr == `I2F_ADDR_RESULT;
  assign hit_flags   = paddr == `I2F_ADDR_FLAGS;
  assign mapped      = hit_ctrl | hit_operand | hit_result | hit_flags;
  assign read_only   = hit_result | hit_flags;

  // writes only land in the access cycle
  assign wr_ctrl    = (phase == access) && pwrite && hit_ctrl;
  assign wr_operand = (phase == access) && pwrite && hit_operand;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_signed     <= 1'b0;
      operand         <= '0;
      result          <= '0;
      flag_inexact    <= 1'b0;
      flag_zero       <= 1'b0;
      capture_pending <= 1'b0;
    end else begin
      if (wr_ctrl) begin
        ctrl_signed <= pwdata[0];
      end
      if (wr_operand) begin
        operand <= pwdata;
      end

      // the core output settles on the new inputs during the next cycle
      capture_pending <= wr_ctrl | wr_operand;

      if (capture_pending) begin
        result       <= res.value;
        flag_inexact <= res.inexact;
        flag_zero    <= res.zero;
      end
    end
  end

  // read data is only driven during a read access, zero otherwise
  always_comb begin
    prdata = '0;
    if ((phase == access) && !pwrite) begin
      if (hit_ctrl) begin
        prdata = {{(`I2F_WIDTH-1){1'b0}}, ctrl_signed};
      end else if (hit_operand) begin
        prdata = operand;
      end else if (hit_result) begin
        prdata = result;
      end else if (hit_flags) begin
        prdata = {{(`I2F_WIDTH-2){1'b0}}, flag_zero, flag_inexact};
      end
    end
  end

  // unmapped addresses and writes to the read-only registers are errors
  assign pslverr = (phase == access) && (!mapped || (pwrite && read_only));

  // every transfer completes in its first access cycle
  assign pready = 1'b1;

  assign req.operand   = operand;
  assign req.is_signed = ctrl_signed;

endmodule

// ==== logic/i2f_top.sv ====
/*
  i2f_top: APB register block wired to the integer to float core
*/
module i2f_top import i2f_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  int_word_t pwdata,
  output int_word_t prdata,
  output logic      pready,
  output logic      pslverr
);

  // operand and mode from the registers, result back from the core
  i2f_req_t req;
  i2f_res_t res;

  i2f_apb_regs regs_i (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .req     (req),
    .res     (res)
  );

  // purely combinational, the register block does the timing
  i2f_core core_i (
    .req (req),
    .res (res)
  );

endmodule

// ==== tests/i2f_checker.sv ====
/*
  i2f_checker: APB protocol and result capture assertions for the
  register block, bound into every i2f_apb_regs instance
*/
`include "i2f_params.svh"

module i2f_checker import i2f_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      psel,
  input logic      penable,
  input logic      pwrite,
  input apb_addr_t paddr,
  input int_word_t prdata,
  input logic      pready,
  input logic      pslverr,
  input logic      capture_pending
);
  timeunit 1ns;
  timeprecision 1ps;

  apb_phase_e phase;

  // the same phase view that the slave takes from psel and penable
  assign phase = !psel ? idle : (!penable ? setup : access);

  // the slave never inserts wait states
  pready_high_a : assert property (@(posedge clk) pready)
    else $error("pready went low");

  // an error response belongs to the access cycle only
  pslverr_access_a : assert property (@(posedge clk) pslverr |-> phase == access)
    else $error("pslverr raised outside an access cycle");

  // the result capture is armed by the edge that takes the operand
  capture_after_write_a : assert property (@(posedge clk) disable iff (reset)
    (phase == access && pwrite && paddr == `I2F_ADDR_OPERAND) |=> capture_pending)
    else $error("capture not pending after an operand write");

  prdata_reset_a : assert property (@(posedge clk) reset |=> prdata == '0)
    else $error("prdata not zero coming out of reset");

endmodule

bind i2f_apb_regs i2f_checker checker_i (
  .clk             (clk),
  .reset           (reset),
  .psel            (psel),
  .penable         (penable),
  .pwrite          (pwrite),
  .paddr           (paddr),
  .prdata          (prdata),
  .pready          (pready),
  .pslverr         (pslverr),
  .capture_pending (capture_pending)
);

// ==== tests/i2f_tb.sv ====
/*
  i2f_tb: APB testbench for the integer to float converter with a
  directed table, random operands against a model, and a watchdog
*/
`include "i2f_params.svh"

module i2f_tb import i2f_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RANDOM   = 40;
  localparam int CLK_PERIOD = 10;

  // a directed case keeps its flags in the {zero, inexact} order of the FLAGS register
  typedef struct packed {
    logic       is_signed;
    int_word_t  operand;
    fp32_t      value;
    logic [1:0] flags;
  } vector_t;

  logic      clk;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  int_word_t pwdata;
  int_word_t prdata;
  logic      pready;
  logic      pslverr;

  vector_t   vectors[$];
  string     names[$];
  bit        table_loaded;
  int        seed;

  i2f_top dut_i (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // starts 1 ns after a rising edge and ends 1 ns after the closing edge
  task automatic apb_transfer(input logic write, input apb_addr_t addr,
                              input int_word_t wdata, output int_word_t rdata,
                              output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // prdata, pslverr and pready are combinational and are sampled mid access cycle
    #2;
    rdata = prdata;
    err   = pslverr;
    check_value("pready in access cycle", 32'd1, 32'(pready));
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input int_word_t data, output logic err);
    int_word_t unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output int_word_t data, output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  // the reference conversion takes the significand by a right shift of the magnitude
  function automatic i2f_res_t model_convert(input int_word_t op, input logic is_signed);
    i2f_res_t    r;
    logic        neg;
    logic [63:0] mag;
    logic [63:0] sig;
    logic [63:0] rem;
    logic [63:0] half;
    int          msb;
    int          drop;
    int          exp;
    r   = '0;
    neg = is_signed && op[`I2F_WIDTH-1];
    mag = neg ? {32'd0, ~op + 32'd1} : {32'd0, op};
    if (mag == 64'd0) begin
      r.zero = 1'b1;
      return r;
    end
    msb = 0;
    for (int b = 0; b < `I2F_WIDTH; b++) begin
      if (mag[b]) begin
        msb = b;
      end
    end
    // the leading one and the mantissa bits stay and the rest is the remainder
    drop = msb - `I2F_MANT_BITS;
    rem  = 64'd0;
    if (drop <= 0) begin
      sig = mag << (-drop);
    end else begin
      sig  = mag >> drop;
      rem  = mag & ((64'd1 << drop) - 64'd1);
      half = 64'd1 << (drop - 1);
      // the nearest value wins and a tie goes to the even significand
      if (rem > half || (rem == half && sig[0])) begin
        sig = sig + 64'd1;
      end
    end
    exp = msb + `I2F_EXP_BIAS;
    // a significand of all ones rounded up becomes the next power of two
    if (sig[`I2F_MANT_BITS+1]) begin
      sig = sig >> 1;
      exp = exp + 1;
    end
    r.value   = {neg, exp[7:0], sig[`I2F_MANT_BITS-1:0]};
    r.inexact = rem != 64'd0;
    return r;
  endfunction

  task automatic add_vector(input string name, input logic sgn, input int_word_t op,
                            input fp32_t value, input logic [1:0] flags);
    names.push_back(name);
    vectors.push_back({sgn, op, value, flags});
  endtask

  // set the mode, write the operand, then read back RESULT and FLAGS
  task automatic run_case(input string name, input logic sgn, input int_word_t op,
                          input fp32_t value, input logic [1:0] flags);
    int_word_t rdata;
    logic      err;
    apb_write(`I2F_ADDR_CTRL, 32'(sgn), err);
    check_value({name, " ctrl pslverr"}, 32'd0, 32'(err));
    apb_write(`I2F_ADDR_OPERAND, op, err);
    check_value({name, " operand pslverr"}, 32'd0, 32'(err));
    apb_read(`I2F_ADDR_RESULT, rdata, err);
    check_value({name, " result"}, value, rdata);
    check_value({name, " result pslverr"}, 32'd0, 32'(err));
    apb_read(`I2F_ADDR_FLAGS, rdata, err);
    check_value({name, " flags"}, 32'(flags), rdata);
    check_value({name, " flags pslverr"}, 32'd0, 32'(err));
  endtask

  initial begin
    int_word_t op;
    int_word_t rdata;
    logic      err;
    i2f_res_t  expected;
    clk     = 1'b0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    seed    = 18;
    add_vector("unsigned one", 1'b0, 32'h0000_0001, 32'h3F80_0000, 2'b00);
    add_vector("unsigned two", 1'b0, 32'h0000_0002, 32'h4000_0000, 2'b00);
    add_vector("unsigned three", 1'b0, 32'h0000_0003, 32'h4040_0000, 2'b00);
    add_vector("unsigned 2^24-1", 1'b0, 32'h00FF_FFFF, 32'h4B7F_FFFF, 2'b00);
    add_vector("unsigned 2^31", 1'b0, 32'h8000_0000, 32'h4F00_0000, 2'b00);
    add_vector("signed minus one", 1'b1, 32'hFFFF_FFFF, 32'hBF80_0000, 2'b00);
    add_vector("signed -2^31", 1'b1, 32'h8000_0000, 32'hCF00_0000, 2'b00);
    add_vector("signed -100", 1'b1, 32'hFFFF_FF9C, 32'hC2C8_0000, 2'b00);
    add_vector("unsigned pattern of -100", 1'b0, 32'hFFFF_FF9C, 32'h4F80_0000, 2'b01);
    add_vector("tie to even down", 1'b0, 32'h0100_0001, 32'h4B80_0000, 2'b01);
    add_vector("tie to even up", 1'b0, 32'h0100_0003, 32'h4B80_0002, 2'b01);
    add_vector("exact 25 bit", 1'b0, 32'h0100_0002, 32'h4B80_0001, 2'b00);
    add_vector("unsigned all ones", 1'b0, 32'hFFFF_FFFF, 32'h4F80_0000, 2'b01);
    add_vector("signed max", 1'b1, 32'h7FFF_FFFF, 32'h4F00_0000, 2'b01);
    add_vector("unsigned zero", 1'b0, 32'h0000_0000, 32'h0000_0000, 2'b10);
    add_vector("signed zero", 1'b1, 32'h0000_0000, 32'h0000_0000, 2'b10);
    table_loaded = 1'b1;

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    foreach (vectors[i]) begin
      run_case(names[i], vectors[i].is_signed, vectors[i].operand,
               vectors[i].value, vectors[i].flags);
    end

    // random operands alternate between unsigned and signed mode
    for (int i = 0; i < N_RANDOM; i++) begin
      op       = $random(seed);
      expected = model_convert(op, i[0]);
      run_case($sformatf("random %0d", i), i[0], op, expected.value,
               {expected.zero, expected.inexact});
    end

    // a write to the read-only RESULT and FLAGS registers is refused and changes nothing
    apb_write(`I2F_ADDR_RESULT, 32'h1234_5678, err);
    check_value("result write pslverr", 32'd1, 32'(err));
    apb_write(`I2F_ADDR_FLAGS, 32'h0000_0003, err);
    check_value("flags write pslverr", 32'd1, 32'(err));
    apb_read(`I2F_ADDR_RESULT, rdata, err);
    check_value("result kept after write", expected.value, rdata);
    apb_read(8'h10, rdata, err);
    check_value("unmapped read pslverr", 32'd1, 32'(err));

    $display("Everything OK");
    $finish;
  end

  // each case takes four transfers of two cycles and the margin covers reset and the last checks
  initial begin
    int timeout_ns;
    wait (table_loaded);
    timeout_ns = (vectors.size() + N_RANDOM) * 8 * CLK_PERIOD + 1000;
    #(timeout_ns);
    $display("watchdog expired after %0d ns before the tests finished", timeout_ns);
    $display("Something failed");
    $fatal(1, "simulation timed out");
  end

endmodule

// ==== all.f ====
+incdir+logic
logic/i2f_pkg.sv
logic/fpuv_lzc.sv
logic/i2f_norm_round.sv
logic/i2f_core.sv
logic/i2f_apb_regs.sv
logic/i2f_top.sv
tests/i2f_checker.sv
tests/i2f_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the converter and its testbench with Verilator, run, and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module i2f_tb -Mdir obj_dir

./obj_dir/Vi2f_tb 2>&1 | tee sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
